//--- common/tpu_pkg.sv
/*
 * Shared definitions for the TPU instruction front end
 *   widths and buffer sizing
 *   front end state enum
 *   host word, buffer entry and commit record structs
 */

package tpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and sizing
	//////////////////////////////////////////////////////////////////////

	localparam int INSTR_WIDTH   = 32;						// Instruction word
	localparam int ID_WIDTH      = 8;						// Thread ID
	localparam int ISSUE_WIDTH   = 6;						// Issue number
	localparam int BUF_DEPTH     = 8;						// Instruction buffer entries

	// Count must reach BUF_DEPTH*4 before it saturates
	localparam int CNT_WIDTH     = $clog2(BUF_DEPTH * 4 + 1);

	localparam int BUF_PTR_WIDTH = $clog2(BUF_DEPTH);		// FIFO pointer
	localparam int BUF_OCC_WIDTH = $clog2(BUF_DEPTH + 1);	// FIFO occupancy, 0..DEPTH

	//////////////////////////////////////////////////////////////////////
	// Front end FSM
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		FE_IDLE   = 3'd0,		// Waiting for a job request
		FE_ISSUE  = 3'd1,		// Expecting the issue number
		FE_THREAD = 3'd2,		// Expecting the thread ID
		FE_INSTR  = 3'd3,		// Loading instructions
		FE_COMMIT = 3'd4		// One cycle commit report
	} fe_state_t;

	//////////////////////////////////////////////////////////////////////
	// Payload structs
	//////////////////////////////////////////////////////////////////////

	// Word from the host, v marks a live word
	typedef struct packed {
		logic                   v;
		logic [INSTR_WIDTH-1:0] data;
	} host_word_t;

	// One instruction buffer slot
	typedef struct packed {
		logic [ID_WIDTH-1:0]    thread_id;
		logic [INSTR_WIDTH-1:0] instr;
	} buf_entry_t;

	// Reported when a job terminates
	typedef struct packed {
		logic [ISSUE_WIDTH-1:0] issue_no;
		logic [CNT_WIDTH-1:0]   instr_count;
	} commit_t;

endpackage

//--- frontend/frontend_fsm.sv
/*
 * Front end control FSM
 *   registers host controls and the buffer full flag
 *   walks issue number, thread ID and instruction words of a job
 *   drives buffer writes, counter control and the commit record
 */

`timescale 1ns/1ps

module frontend_fsm (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          en_exe,		// Execution enable
	input  logic                          req,			// Host request level
	input  logic                          term,			// Job termination
	input  tpu_pkg::host_word_t           word,
	input  logic                          full,			// Buffer full
	input  logic [tpu_pkg::CNT_WIDTH-1:0] count,
	output logic                          nack,
	output logic                          wr_en,
	output tpu_pkg::buf_entry_t           wr_entry,
	output logic                          cnt_clear,
	output logic                          cnt_incr,
	output logic                          commit_valid,
	output tpu_pkg::commit_t              commit_info,
	output logic                          busy,
	output tpu_pkg::fe_state_t            state
);
	import tpu_pkg::*;

	logic                   r_req;
	logic                   r_en_exe;
	logic                   r_term;
	logic                   r_full;
	host_word_t             r_word;
	logic                   accept;
	logic [ISSUE_WIDTH-1:0] issue_no;
	logic [ID_WIDTH-1:0]    thread_id;
	fe_state_t              next_state;

	//////////////////////////////////////////////////////////////////////
	// Input registration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			r_req    <= 1'b0;
			r_en_exe <= 1'b0;
			r_term   <= 1'b0;
			r_full   <= 1'b0;
			r_word   <= '0;
		end else begin
			r_req    <= req;
			r_en_exe <= en_exe;
			r_term   <= term;
			r_full   <= full;
			r_word   <= word;
		end
	end

	// A late word arriving while full is simply dropped
	assign accept = r_req & r_en_exe & r_word.v & ~r_full;

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			FE_IDLE: begin
				if (r_req) begin
					// Issue word may already ride along with the request
					next_state = accept ? FE_THREAD : FE_ISSUE;
				end
			end
			FE_ISSUE: begin
				if (r_term) next_state = FE_COMMIT;
				else if (accept) next_state = FE_THREAD;
			end
			FE_THREAD: begin
				if (r_term) next_state = FE_COMMIT;
				else if (accept) next_state = FE_INSTR;
			end
			FE_INSTR: begin
				if (r_term) next_state = FE_COMMIT;
			end
			FE_COMMIT: next_state = FE_IDLE;
			default:   next_state = FE_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) state <= FE_IDLE;
		else state <= next_state;
	end

	// Job header fields
	always_ff @(posedge clock) begin
		if (state == FE_IDLE && r_req) begin
			issue_no <= accept ? r_word.data[ISSUE_WIDTH-1:0] : '0;
		end else if (state == FE_ISSUE && accept) begin
			issue_no <= r_word.data[ISSUE_WIDTH-1:0];
		end
		if (state == FE_THREAD && accept) begin
			thread_id <= r_word.data[ID_WIDTH-1:0];
		end
	end

	assign wr_en                   = (state == FE_INSTR) & accept;
	assign wr_entry.thread_id      = thread_id;
	assign wr_entry.instr          = r_word.data;
	assign cnt_clear               = (state == FE_IDLE) & r_req;	// Job start
	assign cnt_incr                = wr_en;
	assign commit_valid            = state == FE_COMMIT;
	assign commit_info.issue_no    = issue_no;
	assign commit_info.instr_count = count;
	assign busy                    = state != FE_IDLE;
	assign nack                    = r_full;

	// Registered full lags a cycle, a write must still find room
	assert property (@(posedge clock) disable iff (reset) wr_en |-> !full);

	assert property (@(posedge clock) disable iff (reset) commit_valid |=> !commit_valid);

endmodule

//--- frontend/instr_counter.sv
/*
 * Instruction counter for the current job
 *   cleared at job start, saturates at all ones
 */

`timescale 1ns/1ps

module instr_counter (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          clear,		// Job start
	input  logic                          incr,			// One instruction loaded
	output logic [tpu_pkg::CNT_WIDTH-1:0] count
);
	import tpu_pkg::*;

	logic at_max;

	assign at_max = &count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (incr && !at_max) begin
			count <= count + CNT_WIDTH'(1);	// Hold at max, no wrap
		end
	end

	// Start of a job and an instruction write cannot overlap
	assert property (@(posedge clock) disable iff (reset) !(incr && clear));

endmodule

//--- verilog/instr_buffer.sv
/*
 * Instruction buffer
 *   circular FIFO of buffer entries
 *   single cycle write, fall-through read, full flag
 */

`timescale 1ns/1ps

module instr_buffer (
	input  logic                clock,
	input  logic                reset,
	input  logic                wr_en,
	input  tpu_pkg::buf_entry_t wr_entry,
	input  logic                rd_pop,		// Back end consumes head
	output logic                rd_valid,
	output tpu_pkg::buf_entry_t rd_entry,
	output logic                full
);
	import tpu_pkg::*;

	buf_entry_t               mem [BUF_DEPTH];
	logic [BUF_PTR_WIDTH-1:0] wr_ptr;
	logic [BUF_PTR_WIDTH-1:0] rd_ptr;
	logic [BUF_OCC_WIDTH-1:0] occupancy;
	logic                     push;
	logic                     pop;

	// Wraps at BUF_DEPTH, also for depths that are not a power of two
	function automatic logic [BUF_PTR_WIDTH-1:0] ptr_next(input logic [BUF_PTR_WIDTH-1:0] ptr);
		if (ptr == BUF_PTR_WIDTH'(BUF_DEPTH - 1)) begin
			return '0;
		end
		return ptr + BUF_PTR_WIDTH'(1);
	endfunction

	assign full     = occupancy == BUF_OCC_WIDTH'(BUF_DEPTH);
	assign rd_valid = occupancy != '0;
	assign push     = wr_en & ~full;		// Never overwrite
	assign pop      = rd_pop & rd_valid;	// Pop on empty ignored
	assign rd_entry = mem[rd_ptr];

	//////////////////////////////////////////////////////////////////////
	// Storage and pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (push) wr_ptr <= ptr_next(wr_ptr);
			if (pop) rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   occupancy <= occupancy + BUF_OCC_WIDTH'(1);
				2'b01:   occupancy <= occupancy - BUF_OCC_WIDTH'(1);
				default: occupancy <= occupancy;	// Idle or push+pop
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) wr_en |-> !full);

	// Head entry holds until the back end takes it
	assert property (@(posedge clock) disable iff (reset)
		rd_valid && !rd_pop |=> $stable(rd_entry));

endmodule

//--- verilog/tpu_frontend_top.sv
/*
 * TPU instruction front end top level
 *   control FSM, instruction counter and instruction buffer
 */

`timescale 1ns/1ps

module tpu_frontend_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                en_exe,
	input  logic                req,
	input  logic                term,
	input  tpu_pkg::host_word_t word,
	input  logic                rd_pop,
	output logic                nack,
	output logic                rd_valid,
	output tpu_pkg::buf_entry_t rd_entry,
	output logic                commit_valid,
	output tpu_pkg::commit_t    commit_info,
	output logic                busy
);
	import tpu_pkg::*;

	logic                 wr_en;
	buf_entry_t           wr_entry;
	logic                 full;
	logic                 cnt_clear;
	logic                 cnt_incr;
	logic [CNT_WIDTH-1:0] count;
	fe_state_t            fsm_state;		// Observed by the testbench

	frontend_fsm u_fsm (
		.clock        (clock),
		.reset        (reset),
		.en_exe       (en_exe),
		.req          (req),
		.term         (term),
		.word         (word),
		.full         (full),
		.count        (count),
		.nack         (nack),
		.wr_en        (wr_en),
		.wr_entry     (wr_entry),
		.cnt_clear    (cnt_clear),
		.cnt_incr     (cnt_incr),
		.commit_valid (commit_valid),
		.commit_info  (commit_info),
		.busy         (busy),
		.state        (fsm_state)
	);

	instr_counter u_counter (
		.clock (clock),
		.reset (reset),
		.clear (cnt_clear),
		.incr  (cnt_incr),
		.count (count)
	);

	instr_buffer u_buffer (
		.clock    (clock),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_entry (wr_entry),
		.rd_pop   (rd_pop),
		.rd_valid (rd_valid),
		.rd_entry (rd_entry),
		.full     (full)
	);

endmodule

//--- dv/tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 *   20 ns clock, synchronous reset held for 10 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic reset
);
	localparam int HALF_PERIOD  = 10;		// 20 ns period
	localparam int RESET_CYCLES = 10;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 reset = 1'b0;		// Released off the edge like other inputs
	end

endmodule

//--- dv/tb_tpu_frontend.sv
/*
 * Testbench for the TPU instruction front end
 *   directed tests driving host words, term and back end pops
 *   queue model of expected buffer entries and commit records
 *   watchdog and closing report
 */

`timescale 1ns/1ps

module tb_tpu_frontend;
	import tpu_pkg::*;

	localparam int TEST_COUNT      = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam int WATCHDOG_CYCLES = TEST_COUNT * CYCLES_PER_TEST + 200;	// Reset plus margin
	localparam int COMMIT_WAIT     = 20;

	logic                clock;
	logic                reset;
	logic                en_exe;
	logic                req;
	logic                term;
	logic                rd_pop;
	host_word_t          word;
	logic                nack;
	logic                rd_valid;
	logic                commit_valid;
	logic                busy;
	buf_entry_t          rd_entry;
	commit_t             commit_info;

	buf_entry_t          exp_q[$];			// Entries expected out of the buffer
	logic [31:0]         rng_state = 32'd34067;
	logic [ID_WIDTH-1:0] cur_thread;
	int                  job_instrs      = 0;	// Accepted instructions in the job
	int                  jobs_ended      = 0;
	int                  commits_seen    = 0;
	int                  entries_checked = 0;
	int                  errors          = 0;

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	tpu_frontend_top u_dut (
		.clock        (clock),
		.reset        (reset),
		.en_exe       (en_exe),
		.req          (req),
		.term         (term),
		.word         (word),
		.rd_pop       (rd_pop),
		.nack         (nack),
		.rd_valid     (rd_valid),
		.rd_entry     (rd_entry),
		.commit_valid (commit_valid),
		.commit_info  (commit_info),
		.busy         (busy)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;		// Drive and sample clear of the edge
	endtask

	task automatic report_mismatch(input string test, input string field,
			input logic [63:0] expected, input logic [63:0] actual);
		$display("error %s %s: expected %0h actual %0h", test, field, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string test, input string msg);
		$display("%s: %s", test, msg);
		errors++;
	endtask

	// One word, then one idle cycle; nack in the idle cycle is the flag used for it
	task automatic send_word(input logic [31:0] data, input logic en, input logic v,
			output logic accepted);
		while (nack) next_cycle();
		req       = 1'b1;
		en_exe    = en;
		word.v    = v;
		word.data = data;
		next_cycle();
		accepted  = en && v && !nack;
		word.v    = 1'b0;
		en_exe    = 1'b1;
		next_cycle();
	endtask

	task automatic send_issue(input string test, input logic [31:0] data);
		logic ok;
		job_instrs = 0;
		send_word(data, 1'b1, 1'b1, ok);
		if (!ok) report_failure(test, "issue word was nacked");
	endtask

	task automatic send_thread(input string test, input logic [31:0] data);
		logic ok;
		send_word(data, 1'b1, 1'b1, ok);
		if (!ok) report_failure(test, "thread word was nacked");
		cur_thread = data[ID_WIDTH-1:0];
	endtask

	task automatic send_instr(input logic [31:0] data, input logic en, input logic v,
			output logic ok);
		buf_entry_t e;
		send_word(data, en, v, ok);
		if (ok) begin
			e.thread_id = cur_thread;
			e.instr     = data;
			exp_q.push_back(e);
			job_instrs++;
		end
	endtask

	task automatic wait_commit(input string test, input logic [ISSUE_WIDTH-1:0] exp_issue,
			input int exp_count);
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < COMMIT_WAIT) begin
			if (commit_valid) begin
				seen = 1'b1;
			end else begin
				next_cycle();
				cycles++;
			end
		end
		if (!seen) begin
			report_failure(test, "no commit record after term");
		end else begin
			if (commit_info.issue_no !== exp_issue)
				report_mismatch(test, "issue_no", exp_issue, commit_info.issue_no);
			if (commit_info.instr_count !== CNT_WIDTH'(exp_count))
				report_mismatch(test, "instr_count", exp_count, commit_info.instr_count);
			next_cycle();
			if (commit_valid) report_failure(test, "commit_valid held longer than one cycle");
		end
	endtask

	// Term with req dropped so the FSM settles in idle
	task automatic end_job(input string test, input logic [31:0] issue_data);
		term   = 1'b1;
		req    = 1'b0;
		word.v = 1'b0;
		next_cycle();
		term   = 1'b0;
		jobs_ended++;
		wait_commit(test, issue_data[ISSUE_WIDTH-1:0], job_instrs);
	endtask

	task automatic drain_buffer(input string test);
		int         guard;
		buf_entry_t expected;
		guard = 0;
		while (rd_valid && guard < 4 * BUF_DEPTH) begin
			if (exp_q.size() == 0) begin
				report_failure(test, "buffer returned an entry that was never sent");
			end else begin
				expected = exp_q.pop_front();
				entries_checked++;
				if (rd_entry !== expected) report_mismatch(test, "rd_entry", expected, rd_entry);
			end
			rd_pop = 1'b1;
			next_cycle();
			guard++;
		end
		rd_pop = 1'b0;
		if (exp_q.size() != 0) begin
			report_failure(test, "buffer ran empty with entries still missing");
			exp_q.delete();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_state();
		if (busy !== 1'b0) report_mismatch("reset_state", "busy", 0, busy);
		if (rd_valid !== 1'b0) report_mismatch("reset_state", "rd_valid", 0, rd_valid);
		if (commit_valid !== 1'b0) report_mismatch("reset_state", "commit_valid", 0, commit_valid);
		if (nack !== 1'b0) report_mismatch("reset_state", "nack", 0, nack);
		if (u_dut.fsm_state !== FE_IDLE) report_mismatch("reset_state", "state", FE_IDLE, u_dut.fsm_state);
	endtask

	task automatic single_job();
		logic [31:0] issue_data;
		logic [31:0] thread_data;
		logic [31:0] data;
		logic        ok;
		next_rand(issue_data);
		next_rand(thread_data);
		send_issue("single_job", issue_data);
		send_thread("single_job", thread_data);
		repeat (3) begin
			next_rand(data);
			send_instr(data, 1'b1, 1'b1, ok);
			if (!ok) report_failure("single_job", "instruction nacked with room in the buffer");
		end
		end_job("single_job", issue_data);
		drain_buffer("single_job");
	endtask

	task automatic back_pressure();
		logic [31:0] issue_data;
		logic [31:0] thread_data;
		logic [31:0] data;
		logic        ok;
		logic        nack_seen;
		int          sent;
		next_rand(issue_data);
		next_rand(thread_data);
		send_issue("back_pressure", issue_data);
		send_thread("back_pressure", thread_data);
		sent      = 0;
		nack_seen = 1'b0;
		next_rand(data);
		while (sent < BUF_DEPTH + 4) begin
			send_instr(data, 1'b1, 1'b1, ok);
			if (ok) begin
				sent++;
				next_rand(data);
			end else begin
				// Dropped word, resend once the back end has drained
				nack_seen = 1'b1;
				if (exp_q.size() != BUF_DEPTH)
					report_mismatch("back_pressure", "entries held at nack", BUF_DEPTH, exp_q.size());
				drain_buffer("back_pressure");
			end
		end
		if (!nack_seen) report_failure("back_pressure", "nack never rose with the buffer full");
		end_job("back_pressure", issue_data);
		drain_buffer("back_pressure");
	endtask

	task automatic gating();
		logic [31:0] issue_data;
		logic [31:0] thread_data;
		logic [31:0] data;
		logic        ok;
		next_rand(issue_data);
		next_rand(thread_data);
		send_issue("gating", issue_data);
		send_thread("gating", thread_data);
		for (int i = 0; i < 5; i++) begin
			next_rand(data);
			send_instr(data, i != 1, i != 3, ok);	// en_exe low on 1, v low on 3
		end
		end_job("gating", issue_data);
		drain_buffer("gating");
	endtask

	task automatic early_term();
		logic [31:0] issue_data;
		next_rand(issue_data);
		send_issue("early_term", issue_data);
		end_job("early_term", issue_data);
		if (rd_valid) report_failure("early_term", "buffer holds an entry after an empty job");
		if (busy !== 1'b0) report_mismatch("early_term", "busy", 0, busy);
		if (u_dut.fsm_state !== FE_IDLE) report_mismatch("early_term", "state", FE_IDLE, u_dut.fsm_state);
	endtask

	task automatic back_to_back();
		logic [31:0] r;
		logic [31:0] issue_a;
		logic [31:0] issue_b;
		logic [31:0] data;
		logic        ok;
		next_rand(r);
		issue_a = {r[31:ISSUE_WIDTH], 6'd21};
		send_issue("back_to_back", issue_a);
		send_thread("back_to_back", {r[31:ID_WIDTH], 8'h3a});
		repeat (3) begin
			next_rand(data);
			send_instr(data, 1'b1, 1'b1, ok);
		end
		end_job("back_to_back", issue_a);
		next_rand(r);
		issue_b = {r[31:ISSUE_WIDTH], 6'd42};
		send_issue("back_to_back", issue_b);
		send_thread("back_to_back", {r[31:ID_WIDTH], 8'hc5});
		repeat (2) begin
			next_rand(data);
			send_instr(data, 1'b1, 1'b1, ok);
		end
		end_job("back_to_back", issue_b);
		drain_buffer("back_to_back");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor, sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset && commit_valid) commits_seen++;
	end

	initial begin
		en_exe = 1'b0;
		req    = 1'b0;
		term   = 1'b0;
		word   = '0;
		rd_pop = 1'b0;
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		next_cycle();
		reset_state();
		single_job();
		back_pressure();
		gating();
		early_term();
		back_to_back();
		repeat (2) next_cycle();
		if (commits_seen != jobs_ended) report_mismatch("final", "commit pulses", jobs_ended, commits_seen);
		$display("Summary: %0d entries checked, %0d commits, %0d errors",
			entries_checked, commits_seen, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- src.f
common/tpu_pkg.sv
frontend/frontend_fsm.sv
frontend/instr_counter.sv
verilog/instr_buffer.sv
verilog/tpu_frontend_top.sv
dv/tb_clock_gen.sv
dv/tb_tpu_frontend.sv
